//--- verilog.f
+incdir+hdl
hdl/bp_pkg.sv
hdl/bp_update_if.sv
hdl/bp_decode.sv
hdl/gshare_pht.sv
hdl/bp_btb.sv
hdl/gshare_bp.sv
bench/gshare_bp_sva.sv
bench/gshare_bp_tb.sv

//--- Makefile
TOP := gshare_bp_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

//--- bench/gshare_bp_tb.sv
`default_nettype none

`include "bp_macros.svh"

module gshare_bp_tb;

  localparam logic [`BP_XLEN-1:0] BranchWord = {25'h0012345, `BP_OP_BRANCH};
  localparam logic [`BP_XLEN-1:0] AddiWord   = 32'h00150513;
  // jal x0, +16
  localparam logic [`BP_XLEN-1:0] JalWord    = 32'h0100006f;

  // Stimulus fields first and expected outputs last
  typedef struct {
    logic                fv;
    logic                stall;
    logic [`BP_XLEN-1:0] pc;
    logic [`BP_XLEN-1:0] inst;
    logic                exv;
    logic [`BP_XLEN-1:0] ex_pc;
    logic                ex_taken;
    logic [`BP_XLEN-1:0] ex_target;
    logic [`BP_XLEN-1:0] exp_pc;
    logic                exp_taken;
    bp_pkg::bp_kind_e    exp_kind;
  } step_t;

  logic                clk_i;
  logic                rst_ni;
  logic                stall_i;
  logic                fetch_valid_i;
  logic [`BP_XLEN-1:0] pc_i;
  bp_pkg::inst_u       inst_i;
  logic                ex_valid_i;
  logic [`BP_XLEN-1:0] ex_pc_i;
  logic                ex_taken_i;
  logic [`BP_XLEN-1:0] ex_target_i;
  logic [`BP_XLEN-1:0] pred_pc_o;
  logic                pred_taken_o;
  bp_pkg::bp_kind_e    pred_kind_o;

  // Reference model state
  logic [`BP_GHR_BITS-1:0] m_ghr;
  bp_pkg::pht_ctr_t        m_pht     [`BP_PHT_DEPTH];
  logic                    m_btb_v   [`BP_BTB_DEPTH];
  logic [`BP_XLEN-1:6]     m_btb_tag [`BP_BTB_DEPTH];
  logic [`BP_XLEN-1:0]     m_btb_tgt [`BP_BTB_DEPTH];

  logic [31:0] lfsr_q;
  step_t       steps [$];
  int          cycles;
  int          limit;

  gshare_bp dut_i (.*);

  always #2 clk_i = ~clk_i;

  // ====================
  // Helpers
  // ====================

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_addr(input string name, input logic [`BP_XLEN-1:0] exp,
                            input logic [`BP_XLEN-1:0] act);
    if (act !== exp) begin
      abort_run($sformatf("Fail time=%0t signal=%s expected=%h actual=%h",
                          $time, name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("Fail time=%0t signal=%s expected=%b actual=%b",
                          $time, name, exp, act));
    end
  endtask

  task automatic check_kind(input string name, input bp_pkg::bp_kind_e exp,
                            input bp_pkg::bp_kind_e act);
    if (act !== exp) begin
      abort_run($sformatf("Fail time=%0t signal=%s expected=%s actual=%s",
                          $time, name, exp.name(), act.name()));
    end
  endtask

  // Galois step giving one bit per call
  function automatic logic next_bit();
    logic b;
    b      = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (b) lfsr_q = lfsr_q ^ 32'h80200003;
    return b;
  endfunction

  function automatic logic [`BP_XLEN-1:0] rand_word(input int n);
    logic [`BP_XLEN-1:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[`BP_XLEN-2:0], next_bit()};
    return v;
  endfunction

  // Expected outputs from model state before the model takes the update
  task automatic add_step(input logic fv, input logic st, input logic [`BP_XLEN-1:0] pc,
                          input logic [`BP_XLEN-1:0] inst, input logic exv,
                          input logic [`BP_XLEN-1:0] ex_pc, input logic tk,
                          input logic [`BP_XLEN-1:0] tgt);
    step_t                   s;
    logic [`BP_GHR_BITS-1:0] idx;
    bp_pkg::pht_ctr_t        c;
    s = '{fv, st, pc, inst, exv, ex_pc, tk, tgt, pc + 4, 1'b0, bp_pkg::BP_NONE};
    if (fv && !st) begin
      if (inst[6:0] == `BP_OP_JAL) begin
        s.exp_pc    = pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        s.exp_taken = 1'b1;
        s.exp_kind  = bp_pkg::BP_JUMP;
      end else if (inst[6:0] == `BP_OP_BRANCH && m_pht[pc[8:1] ^ m_ghr][1] &&
                   m_btb_v[pc[4:1]] && m_btb_tag[pc[4:1]] == pc[31:6]) begin
        s.exp_pc    = m_btb_tgt[pc[4:1]];
        s.exp_taken = 1'b1;
        s.exp_kind  = bp_pkg::BP_BRANCH;
      end
    end
    // Stalled reports never reach the tables
    if (exv && !st) begin
      idx = ex_pc[8:1] ^ m_ghr;
      c   = m_pht[idx];
      if (tk && c != 2'b11) c = c + 2'd1;
      if (!tk && c != 2'b00) c = c - 2'd1;
      m_pht[idx] = c;
      m_ghr      = {m_ghr[`BP_GHR_BITS-2:0], tk};
      if (tk) begin
        m_btb_v[ex_pc[4:1]]   = 1'b1;
        m_btb_tag[ex_pc[4:1]] = ex_pc[31:6];
        m_btb_tgt[ex_pc[4:1]] = tgt;
      end
    end
    steps.push_back(s);
  endtask

  // ====================
  // Stimulus table
  // ====================

  task automatic build_table();
    logic [`BP_XLEN-1:0] pcs [4];
    logic [`BP_XLEN-1:0] a;
    logic [`BP_XLEN-1:0] w;
    logic [1:0]          sel;
    pcs = '{32'h100, 32'h104, 32'h1100, 32'h2208};
    // Fresh tables
    add_step(1'b1, 1'b0, 32'h100, BranchWord, 1'b0, 0, 1'b0, 0);
    add_step(1'b0, 1'b0, 32'h100, BranchWord, 1'b0, 0, 1'b0, 0);
    // Untrained JAL with random offsets
    for (int i = 0; i < 4; i++) begin
      w = (rand_word(25) << 7) | {25'h0, `BP_OP_JAL};
      a = rand_word(30) << 2;
      add_step(1'b1, 1'b0, a, w, 1'b0, 0, 1'b0, 0);
    end
    // History to all ones
    for (int i = 0; i < 8; i++) begin
      add_step(1'b1, 1'b0, 32'h100, BranchWord, 1'b1, 32'h3c8, 1'b1, 32'h800);
    end
    // Two taken at 0x100
    add_step(1'b1, 1'b0, 32'h100, BranchWord, 1'b1, 32'h100, 1'b1, 32'h5a0);
    add_step(1'b1, 1'b0, 32'h100, BranchWord, 1'b1, 32'h100, 1'b1, 32'h5a0);
    add_step(1'b1, 1'b0, 32'h100, BranchWord, 1'b0, 0, 1'b0, 0);
    // Trained PC holding a non-branch word
    add_step(1'b1, 1'b0, 32'h100, AddiWord, 1'b0, 0, 1'b0, 0);
    // Same BTB index with another tag
    add_step(1'b1, 1'b0, 32'h1100, BranchWord, 1'b0, 0, 1'b0, 0);
    // Report held through stall at the PC that just missed on its tag
    add_step(1'b1, 1'b1, 32'h1100, BranchWord, 1'b1, 32'h1100, 1'b1, 32'h9000);
    add_step(1'b1, 1'b1, 32'h1100, JalWord, 1'b1, 32'h1100, 1'b1, 32'h9000);
    // First unstalled fetch still misses
    add_step(1'b1, 1'b0, 32'h1100, BranchWord, 1'b1, 32'h1100, 1'b1, 32'h9000);
    add_step(1'b0, 1'b0, 32'h1100, JalWord, 1'b0, 0, 1'b0, 0);
    add_step(1'b1, 1'b0, 32'h1100, BranchWord, 1'b0, 0, 1'b0, 0);
    add_step(1'b1, 1'b0, 32'h1100, JalWord, 1'b0, 0, 1'b0, 0);
    // Random updates over a few PCs
    for (int i = 0; i < 32; i++) begin
      sel = {next_bit(), next_bit()};
      a   = pcs[sel];
      sel = {next_bit(), next_bit()};
      add_step(1'b1, 1'b0, a, BranchWord, next_bit(), pcs[sel], next_bit(),
               rand_word(12) << 2);
    end
  endtask

  // ====================
  // Run
  // ====================

  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      abort_run($sformatf("Timeout: run still going after %0d cycles", cycles));
    end
  end

  initial begin
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    stall_i       = 1'b0;
    fetch_valid_i = 1'b0;
    pc_i          = '0;
    inst_i        = '0;
    ex_valid_i    = 1'b0;
    ex_pc_i       = '0;
    ex_taken_i    = 1'b0;
    ex_target_i   = '0;
    cycles        = 0;
    limit         = 0;
    lfsr_q        = 32'h96c;
    m_ghr         = '0;
    for (int i = 0; i < `BP_PHT_DEPTH; i++) m_pht[i] = bp_pkg::PHT_CTR_INIT;
    for (int i = 0; i < `BP_BTB_DEPTH; i++) m_btb_v[i] = 1'b0;
    build_table();
    // Rows plus reset plus slack
    limit = steps.size() + 5 + 20;
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    foreach (steps[i]) begin
      @(negedge clk_i);
      fetch_valid_i = steps[i].fv;
      stall_i       = steps[i].stall;
      pc_i          = steps[i].pc;
      inst_i        = steps[i].inst;
      ex_valid_i    = steps[i].exv;
      ex_pc_i       = steps[i].ex_pc;
      ex_taken_i    = steps[i].ex_taken;
      ex_target_i   = steps[i].ex_target;
      // Away from both edges
      #1;
      check_addr("pred_pc_o", steps[i].exp_pc, pred_pc_o);
      check_bit("pred_taken_o", steps[i].exp_taken, pred_taken_o);
      check_kind("pred_kind_o", steps[i].exp_kind, pred_kind_o);
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/gshare_bp_sva.sv
`default_nettype none

// Output sanity on the predictor top level
module gshare_bp_sva (
  input logic             clk_i,
  input logic             rst_ni,
  input logic             stall_i,
  input logic             fetch_valid_i,
  input logic             pred_taken_o,
  input bp_pkg::bp_kind_e pred_kind_o
);

  // Taken only on a live fetch
  taken_needs_fetch: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pred_taken_o |-> (fetch_valid_i && !stall_i))
    else $error("pred_taken_o high without an active fetch");

  // Kind follows the taken flag
  kind_matches_taken: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (pred_kind_o == bp_pkg::BP_NONE) == !pred_taken_o)
    else $error("pred_kind_o disagrees with pred_taken_o");

  // Quiet on the first cycle out of reset
  quiet_after_reset: assert property (@(posedge clk_i) $rose(rst_ni) |-> !pred_taken_o)
    else $error("pred_taken_o high right after reset");

endmodule

bind gshare_bp gshare_bp_sva sva_i (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .stall_i       (stall_i),
  .fetch_valid_i (fetch_valid_i),
  .pred_taken_o  (pred_taken_o),
  .pred_kind_o   (pred_kind_o)
);

`default_nettype wire

//--- hdl/gshare_bp.sv
`default_nettype none

`include "bp_macros.svh"

module gshare_bp (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                stall_i,
  input  logic                fetch_valid_i,
  input  logic [`BP_XLEN-1:0] pc_i,
  input  bp_pkg::inst_u       inst_i,
  input  logic                ex_valid_i,
  input  logic [`BP_XLEN-1:0] ex_pc_i,
  input  logic                ex_taken_i,
  input  logic [`BP_XLEN-1:0] ex_target_i,
  output logic [`BP_XLEN-1:0] pred_pc_o,
  output logic                pred_taken_o,
  output bp_pkg::bp_kind_e    pred_kind_o
);

  // RV32 instruction size in bytes
  localparam logic [`BP_XLEN-1:0] InstBytes = 4;

  logic                is_jal;
  logic                is_branch;
  logic [`BP_XLEN-1:0] jal_target;
  logic                pht_taken;
  logic                btb_hit;
  logic [`BP_XLEN-1:0] btb_target;
  logic [`BP_XLEN-1:0] pc_seq;

  // ====================
  // Update path
  // ====================

  bp_update_if upd_if ();

  // Execute holds its report through stall
  assign upd_if.valid  = ex_valid_i && !stall_i;
  assign upd_if.pc     = ex_pc_i;
  assign upd_if.taken  = ex_taken_i;
  assign upd_if.target = ex_target_i;

  // ====================
  // Lookup blocks
  // ====================

  bp_decode u_decode (
    .inst_i       (inst_i),
    .pc_i         (pc_i),
    .is_jal_o     (is_jal),
    .is_branch_o  (is_branch),
    .jal_target_o (jal_target)
  );

  gshare_pht u_pht (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .pc_i    (pc_i),
    .upd     (upd_if),
    .taken_o (pht_taken)
  );

  bp_btb u_btb (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .pc_i     (pc_i),
    .upd      (upd_if),
    .hit_o    (btb_hit),
    .target_o (btb_target)
  );

  // ====================
  // Prediction select
  // ====================

  assign pc_seq = pc_i + InstBytes;

  always_comb begin
    // Sequential by default
    pred_pc_o    = pc_seq;
    pred_taken_o = 1'b0;
    pred_kind_o  = bp_pkg::BP_NONE;
    if (fetch_valid_i && !stall_i) begin
      if (is_jal) begin
        // Direct jump, always taken
        pred_pc_o    = jal_target;
        pred_taken_o = 1'b1;
        pred_kind_o  = bp_pkg::BP_JUMP;
      end else if (is_branch && pht_taken && btb_hit) begin
        // Counter says taken and a target is known
        pred_pc_o    = btb_target;
        pred_taken_o = 1'b1;
        pred_kind_o  = bp_pkg::BP_BRANCH;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/bp_btb.sv
`default_nettype none

`include "bp_macros.svh"

module bp_btb (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic [`BP_XLEN-1:0] pc_i,
  bp_update_if.tbl            upd,
  output logic                hit_o,
  output logic [`BP_XLEN-1:0] target_o
);

  localparam int unsigned IdxBits = $clog2(`BP_BTB_DEPTH);
  // Tag starts above index plus two low bits
  localparam int unsigned TagLsb  = IdxBits + 2;

  // ====================
  // Storage
  // ====================

  logic                       valid_q  [`BP_BTB_DEPTH];
  logic [`BP_XLEN-1:TagLsb]   tag_q    [`BP_BTB_DEPTH];
  logic [`BP_XLEN-1:0]        target_q [`BP_BTB_DEPTH];

  logic [IdxBits-1:0] rd_idx;
  logic [IdxBits-1:0] wr_idx;

  // Direct mapped, bits 4:1 of the PC
  assign rd_idx = pc_i[IdxBits:1];
  assign wr_idx = upd.pc[IdxBits:1];

  // ====================
  // Lookup
  // ====================

  // Needs valid entry and full tag match
  assign hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == pc_i[`BP_XLEN-1:TagLsb]);
  assign target_o = target_q[rd_idx];

  // ====================
  // Fill
  // ====================

  // Valid bits only
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int i = 0; i < `BP_BTB_DEPTH; i++) begin
        valid_q[i] <= 1'b0;
      end
    end else if (upd.valid && upd.taken) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  // Tag and target written with the valid bit
  always_ff @(posedge clk_i) begin
    if (upd.valid && upd.taken) begin
      tag_q[wr_idx]    <= upd.pc[`BP_XLEN-1:TagLsb];
      target_q[wr_idx] <= upd.target;
    end
  end

  // Not-taken reports leave the entry alone

endmodule

`default_nettype wire

//--- hdl/gshare_pht.sv
`default_nettype none

`include "bp_macros.svh"

module gshare_pht (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic [`BP_XLEN-1:0] pc_i,
  bp_update_if.tbl            upd,
  output logic                taken_o
);

  localparam int unsigned IdxBits = `BP_GHR_BITS;

  // Global history, newest outcome in bit 0
  logic [`BP_GHR_BITS-1:0] ghr_q;

  // Counter table
  bp_pkg::pht_ctr_t pht_q [`BP_PHT_DEPTH];

  logic [IdxBits-1:0] rd_idx;
  logic [IdxBits-1:0] wr_idx;
  bp_pkg::pht_ctr_t   wr_ctr;

  // ====================
  // Index
  // ====================

  // Halfword-aligned PC bits hashed with history
  assign rd_idx = pc_i[IdxBits:1] ^ ghr_q;
  // Update uses the history as it stands now
  assign wr_idx = upd.pc[IdxBits:1] ^ ghr_q;

  // MSB of the counter is the prediction
  assign taken_o = pht_q[rd_idx][1];

  // ====================
  // Saturating step
  // ====================

  always_comb begin
    wr_ctr = pht_q[wr_idx];
    if (upd.taken) begin
      // Stop at strongly taken
      if (wr_ctr != 2'b11) wr_ctr = wr_ctr + 2'd1;
    end else begin
      // Stop at strongly not-taken
      if (wr_ctr != 2'b00) wr_ctr = wr_ctr - 2'd1;
    end
  end

  // Counter and history move on the same edge
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      ghr_q <= '0;
      for (int i = 0; i < `BP_PHT_DEPTH; i++) begin
        pht_q[i] <= bp_pkg::PHT_CTR_INIT;
      end
    end else if (upd.valid) begin
      pht_q[wr_idx] <= wr_ctr;
      // Shift in actual outcome
      ghr_q         <= {ghr_q[`BP_GHR_BITS-2:0], upd.taken};
    end
  end

endmodule

`default_nettype wire

//--- hdl/bp_decode.sv
`default_nettype none

`include "bp_macros.svh"

module bp_decode (
  input  bp_pkg::inst_u       inst_i,
  input  logic [`BP_XLEN-1:0] pc_i,
  output logic                is_jal_o,
  output logic                is_branch_o,
  output logic [`BP_XLEN-1:0] jal_target_o
);

  // Sign-extended J immediate
  logic [`BP_XLEN-1:0] j_imm;

  // ====================
  // Opcode match
  // ====================

  // Opcode sits in the same bits for both views
  assign is_branch_o = (inst_i.b.opcode == `BP_OP_BRANCH);
  assign is_jal_o    = (inst_i.j.opcode == `BP_OP_JAL);

  // ====================
  // JAL target
  // ====================

  // Reassemble imm[20:1], bit 0 always zero
  assign j_imm = {
    {(`BP_XLEN - 20){inst_i.j.imm20}},
    inst_i.j.imm19_12,
    inst_i.j.imm11,
    inst_i.j.imm10_1,
    1'b0
  };

  // PC relative, no wrap handling needed
  assign jal_target_o = pc_i + j_imm;

  // Branch targets come from the BTB,
  // so the B immediate is never assembled here

endmodule

`default_nettype wire

//--- hdl/bp_update_if.sv
`default_nettype none

`include "bp_macros.svh"

// One resolved conditional branch per cycle, no back-pressure
interface bp_update_if;

  logic                valid;
  logic [`BP_XLEN-1:0] pc;
  logic                taken;
  logic [`BP_XLEN-1:0] target;

  // Top level side
  modport src (
    output valid,
    output pc,
    output taken,
    output target
  );

  // PHT and BTB side, consumed on every edge with valid high
  modport tbl (
    input valid,
    input pc,
    input taken,
    input target
  );

endinterface

`default_nettype wire

//--- hdl/bp_pkg.sv
`default_nettype none

package bp_pkg;

  // ====================
  // Instruction word
  // ====================

  // B-type layout, imm[12|10:5] ... imm[4:1|11]
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } inst_b_t;

  // J-type layout, imm[20|10:1|11|19:12]
  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } inst_j_t;

  // Same fetched word seen as branch or as JAL
  typedef union packed {
    inst_b_t b;
    inst_j_t j;
  } inst_u;

  // Which rule picked the prediction
  typedef enum logic [1:0] {
    BP_NONE   = 2'd0,
    BP_JUMP   = 2'd1,
    BP_BRANCH = 2'd2
  } bp_kind_e;

  // Two-bit saturating counter, MSB means taken
  typedef logic [1:0] pht_ctr_t;

  // Weakly not-taken
  localparam pht_ctr_t PHT_CTR_INIT = 2'b01;

endpackage

`default_nettype wire

//--- hdl/bp_macros.svh
`ifndef BP_MACROS_SVH
`define BP_MACROS_SVH

// ====================
// Widths
// ====================

// Address and instruction word width
`define BP_XLEN 32

// Global history length, also the PHT index width
`define BP_GHR_BITS 8

// ====================
// Table depths
// ====================

// One counter per history/PC index
`define BP_PHT_DEPTH 256
`define BP_BTB_DEPTH 16

// ====================
// RV32 opcodes
// ====================

`define BP_OP_BRANCH 7'b1100011
`define BP_OP_JAL    7'b1101111

`endif
